// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench, a failed build or run counts as failure
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module ddc_backend_tb -Mdir obj_dir -o ddc_sim > build.log 2>&1 \
    && ./obj_dir/ddc_sim > sim.log 2>&1 \
    || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

// ==== source/cic_compfir.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddc_cfg.svh"

module cic_compfir (
    input  wire logic                i_clock,
    input  wire logic                i_reset,
    input  wire ddc_pkg::iq_sample_t i_sample,
    input  wire logic                i_valid,
    output logic                     o_ready,
    output ddc_pkg::iq_wide_t        o_result,
    output logic                     o_valid
);
    import ddc_pkg::*;

    localparam int W      = `DDC_WIDTH;
    localparam int FRAC   = `DDC_FIR_FRAC;
    localparam int WIDE_W = `DDC_WIDE_WIDTH;
    localparam int HALF   = 16;
    localparam int TAPS   = 2 * HALF + 1;
    localparam int CNT_W  = $clog2(HALF);
    localparam int COEF_W = 18;
    localparam int PROD_W = W + 1 + COEF_W;
    localparam int ACC_W  = WIDE_W + FRAC - 1;
    localparam int RAILS  = 2;

    logic signed [W-1:0] rail_in [RAILS];
    logic [CNT_W-1:0]    count;
    logic                active;
    logic                accept;
    logic                mac_start;
    logic                mac_last;
    logic [2:0]          start_dly;
    logic [3:0]          last_dly;

    assign rail_in[0] = i_sample.inph;
    assign rail_in[1] = i_sample.quad;

    assign accept   = i_valid && o_ready;
    assign mac_last = active && (count == '0);

    // Busy for HALF cycles, one tap pair per cycle
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            count     <= '0;
            active    <= 1'b0;
            o_ready   <= 1'b0;
            mac_start <= 1'b0;
        end else begin
            mac_start <= accept;
            if (accept) begin
                count   <= CNT_W'(HALF - 1);
                active  <= 1'b1;
                o_ready <= 1'b0;
            end else if (mac_last) begin
                active  <= 1'b0;
                o_ready <= 1'b1;
            end else if (active) begin
                count <= count - 1'b1;
            end else begin
                o_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            start_dly <= '0;
            last_dly  <= '0;
        end else begin
            start_dly <= {start_dly[1:0], mac_start};
            last_dly  <= {last_dly[2:0], mac_last};
        end
    end

    // Tap delay line, newest sample at index 0
    logic signed [W-1:0] tdl [RAILS][TAPS];

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int r = 0; r < RAILS; r++) begin
                for (int t = 0; t < TAPS; t++) begin
                    tdl[r][t] <= '0;
                end
            end
        end else if (accept) begin
            for (int r = 0; r < RAILS; r++) begin
                tdl[r][0] <= rail_in[r];
                for (int t = 1; t < TAPS; t++) begin
                    tdl[r][t] <= tdl[r][t-1];
                end
            end
        end
    end

    // Coefficients in Q2.16, outer pair first
    logic signed [COEF_W-1:0] coef_reg0;

    always_ff @(posedge i_clock) begin
        case (count)
            4'd15:   coef_reg0 <= 18'sd163;
            4'd14:   coef_reg0 <= -18'sd629;
            4'd13:   coef_reg0 <= -18'sd223;
            4'd12:   coef_reg0 <= 18'sd2447;
            4'd11:   coef_reg0 <= -18'sd2564;
            4'd10:   coef_reg0 <= -18'sd3222;
            4'd9:    coef_reg0 <= 18'sd9836;
            4'd8:    coef_reg0 <= -18'sd4201;
            4'd7:    coef_reg0 <= -18'sd15254;
            4'd6:    coef_reg0 <= 18'sd23990;
            4'd5:    coef_reg0 <= 18'sd3427;
            4'd4:    coef_reg0 <= -18'sd44842;
            4'd3:    coef_reg0 <= 18'sd35095;
            4'd2:    coef_reg0 <= 18'sd42736;
            4'd1:    coef_reg0 <= -18'sd87836;
            default: coef_reg0 <= -18'sd8075;
        endcase
    end

    logic signed [W-1:0] lhs_reg0    [RAILS];
    logic signed [W-1:0] rhs_reg0    [RAILS];
    logic signed [W-1:0] centre_reg0 [RAILS];

    always_ff @(posedge i_clock) begin
        for (int r = 0; r < RAILS; r++) begin
            lhs_reg0[r] <= tdl[r][HALF - 1 - int'(count)];
            rhs_reg0[r] <= tdl[r][HALF + 1 + int'(count)];
            // Centre tap kept until the final add
            if (mac_last) begin
                centre_reg0[r] <= tdl[r][HALF];
            end
        end
    end

    // Preadd, multiply, accumulate
    logic signed [W:0]        pre_reg1  [RAILS];
    logic signed [COEF_W-1:0] coef_reg1;
    logic signed [PROD_W-1:0] prod_reg2 [RAILS];
    logic signed [ACC_W-1:0]  acc_reg3  [RAILS];

    always_ff @(posedge i_clock) begin
        coef_reg1 <= coef_reg0;
        for (int r = 0; r < RAILS; r++) begin
            pre_reg1[r]  <= (W+1)'(lhs_reg0[r]) + (W+1)'(rhs_reg0[r]);
            prod_reg2[r] <= pre_reg1[r] * coef_reg1;
            if (start_dly[2]) begin
                acc_reg3[r] <= ACC_W'(prod_reg2[r]);
            end else begin
                acc_reg3[r] <= acc_reg3[r] + ACC_W'(prod_reg2[r]);
            end
        end
    end

    // Centre tap at weight 1.0
    logic signed [ACC_W-1:0] sum_reg4 [RAILS];
    logic                    valid_reg4;

    always_ff @(posedge i_clock) begin
        if (last_dly[3]) begin
            for (int r = 0; r < RAILS; r++) begin
                sum_reg4[r] <= acc_reg3[r] + (ACC_W'(centre_reg0[r]) <<< FRAC);
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            valid_reg4 <= 1'b0;
        end else begin
            valid_reg4 <= last_dly[3];
        end
    end

    // Convergent rounding, ties go to the even neighbour
    logic signed [WIDE_W-1:0] trunc    [RAILS];
    logic [RAILS-1:0]         round_up;
    iq_wide_t                 rounded;

    always_comb begin
        for (int r = 0; r < RAILS; r++) begin
            trunc[r]    = {sum_reg4[r][ACC_W-1], sum_reg4[r][ACC_W-1:FRAC]};
            round_up[r] = sum_reg4[r][FRAC-1]
                          && ((|sum_reg4[r][FRAC-2:0]) || sum_reg4[r][FRAC]);
        end
    end

    assign rounded = '{
        inph: trunc[0] + WIDE_W'(round_up[0]),
        quad: trunc[1] + WIDE_W'(round_up[1])
    };

    always_ff @(posedge i_clock) begin
        o_result <= rounded;
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= valid_reg4;
        end
    end

endmodule : cic_compfir

`default_nettype wire

// ==== source/cic_decimator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddc_cfg.svh"

module cic_decimator (
    input  wire logic                i_clock,
    input  wire logic                i_reset,
    input  wire ddc_pkg::iq_sample_t i_sample,
    input  wire logic                i_valid,
    input  wire logic                i_ready,
    output ddc_pkg::iq_sample_t      o_sample,
    output logic                     o_valid
);
    import ddc_pkg::*;

    localparam int W      = `DDC_WIDTH;
    localparam int GROWTH = `DDC_CIC_GROWTH;
    localparam int STAGES = `DDC_CIC_STAGES;
    localparam int RATE   = `DDC_CIC_RATE;
    localparam int ACC_W  = W + GROWTH;
    localparam int PH_W   = $clog2(RATE);
    localparam int RAILS  = 2;

    localparam logic [PH_W-1:0] PHASE_LAST = PH_W'(RATE - 1);

    logic signed [W-1:0]     rail_in  [RAILS];
    logic signed [ACC_W-1:0] integ    [RAILS][STAGES];
    logic signed [ACC_W-1:0] comb_dly [RAILS][STAGES];
    logic signed [ACC_W-1:0] comb_tap [RAILS][STAGES+1];
    logic signed [ACC_W-1:0] comb_out [RAILS];
    logic [PH_W-1:0]         phase;
    logic                    dump_integ;
    logic                    dump_comb;
    iq_sample_t              scaled;

    assign rail_in[0] = i_sample.inph;
    assign rail_in[1] = i_sample.quad;

    // Every RATE-th strobe hands the integrator state to the combs
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            phase      <= '0;
            dump_integ <= 1'b0;
        end else begin
            dump_integ <= 1'b0;
            if (i_valid) begin
                if (phase == PHASE_LAST) begin
                    phase      <= '0;
                    dump_integ <= 1'b1;
                end else begin
                    phase <= phase + 1'b1;
                end
            end
        end
    end

    // Integrators wrap; the combs undo the overflow
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int r = 0; r < RAILS; r++) begin
                for (int s = 0; s < STAGES; s++) begin
                    integ[r][s] <= '0;
                end
            end
        end else if (i_valid) begin
            for (int r = 0; r < RAILS; r++) begin
                integ[r][0] <= integ[r][0] + ACC_W'(rail_in[r]);
                for (int s = 1; s < STAGES; s++) begin
                    integ[r][s] <= integ[r][s] + integ[r][s-1];
                end
            end
        end
    end

    // Comb chain, differential delay of one decimated sample
    always_comb begin
        for (int r = 0; r < RAILS; r++) begin
            comb_tap[r][0] = integ[r][STAGES-1];
            for (int s = 0; s < STAGES; s++) begin
                comb_tap[r][s+1] = comb_tap[r][s] - comb_dly[r][s];
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            dump_comb <= 1'b0;
            for (int r = 0; r < RAILS; r++) begin
                for (int s = 0; s < STAGES; s++) begin
                    comb_dly[r][s] <= '0;
                end
            end
        end else begin
            dump_comb <= dump_integ;
            if (dump_integ) begin
                for (int r = 0; r < RAILS; r++) begin
                    for (int s = 0; s < STAGES; s++) begin
                        comb_dly[r][s] <= comb_tap[r][s];
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (dump_integ) begin
            for (int r = 0; r < RAILS; r++) begin
                comb_out[r] <= comb_tap[r][STAGES];
            end
        end
    end

    // Drop the growth bits for unit DC gain
    assign scaled = '{inph: comb_out[0][ACC_W-1:GROWTH], quad: comb_out[1][ACC_W-1:GROWTH]};

    // Sample is held until the FIR takes it
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else if (dump_comb) begin
            o_valid <= 1'b1;
        end else if (o_valid && i_ready) begin
            o_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clock) begin
        if (dump_comb) begin
            o_sample <= scaled;
        end
    end

endmodule : cic_decimator

`default_nettype wire

// ==== source/ddc_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddc_backend (
    input  wire logic                i_clock,
    input  wire logic                i_reset,
    input  wire ddc_pkg::iq_sample_t i_sample,
    input  wire logic                i_valid,
    output ddc_pkg::iq_sample_t      o_sample,
    output ddc_pkg::iq_oflow_t       o_oflow,
    output logic                     o_valid
);
    import ddc_pkg::*;

    // Decimator to FIR, held sample with handshake
    iq_sample_t dec_sample;
    logic       dec_valid;
    logic       fir_ready;

    // FIR to saturator, single-cycle pulse
    iq_wide_t   fir_result;
    logic       fir_valid;

    cic_decimator i_decimator (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_sample (i_sample),
        .i_valid  (i_valid),
        .i_ready  (fir_ready),
        .o_sample (dec_sample),
        .o_valid  (dec_valid)
    );

    cic_compfir i_compfir (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_sample (dec_sample),
        .i_valid  (dec_valid),
        .o_ready  (fir_ready),
        .o_result (fir_result),
        .o_valid  (fir_valid)
    );

    iq_saturator i_saturator (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_result (fir_result),
        .i_valid  (fir_valid),
        .o_sample (o_sample),
        .o_oflow  (o_oflow),
        .o_valid  (o_valid)
    );

endmodule : ddc_backend

`default_nettype wire

// ==== source/ddc_cfg.svh ====
`ifndef DDC_CFG_SVH
`define DDC_CFG_SVH

// Sample width of each rail
`define DDC_WIDTH       16

// CIC decimation rate and stage count
`define DDC_CIC_RATE    32
`define DDC_CIC_STAGES  3

// Register growth through the CIC, stages times log2 of the rate
`define DDC_CIC_GROWTH  (`DDC_CIC_STAGES * $clog2(`DDC_CIC_RATE))

// FIR accumulator headroom and coefficient fraction bits
`define DDC_FIR_GUARD   20
`define DDC_FIR_FRAC    16

// Rounded FIR result, one bit wider than the accumulator minus fraction
`define DDC_WIDE_WIDTH  (`DDC_WIDTH + 18 + `DDC_FIR_GUARD - `DDC_FIR_FRAC + 2)

`endif

// ==== source/ddc_pkg.sv ====
`default_nettype none

`include "ddc_cfg.svh"

package ddc_pkg;

    // One complex sample at the rail width
    typedef struct packed {
        logic signed [`DDC_WIDTH-1:0] inph;
        logic signed [`DDC_WIDTH-1:0] quad;
    } iq_sample_t;

    // Rounded FIR output before clamping
    typedef struct packed {
        logic signed [`DDC_WIDE_WIDTH-1:0] inph;
        logic signed [`DDC_WIDE_WIDTH-1:0] quad;
    } iq_wide_t;

    // Clamp direction per rail
    typedef struct packed {
        logic inph_pos;
        logic inph_neg;
        logic quad_pos;
        logic quad_neg;
    } iq_oflow_t;

endpackage : ddc_pkg

`default_nettype wire

// ==== source/iq_saturator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddc_cfg.svh"

module iq_saturator (
    input  wire logic              i_clock,
    input  wire logic              i_reset,
    input  wire ddc_pkg::iq_wide_t i_result,
    input  wire logic              i_valid,
    output ddc_pkg::iq_sample_t    o_sample,
    output ddc_pkg::iq_oflow_t     o_oflow,
    output logic                   o_valid
);
    import ddc_pkg::*;

    localparam int W      = `DDC_WIDTH;
    localparam int WIDE_W = `DDC_WIDE_WIDTH;
    localparam int RAILS  = 2;

    logic signed [WIDE_W-1:0] rail_in  [RAILS];
    logic signed [W-1:0]      rail_out [RAILS];
    logic [RAILS-1:0]         rail_pos;
    logic [RAILS-1:0]         rail_neg;
    iq_sample_t               sample_next;
    iq_oflow_t                oflow_next;

    assign rail_in[0] = i_result.inph;
    assign rail_in[1] = i_result.quad;

    // Upper bits must all match the output sign bit
    always_comb begin
        for (int r = 0; r < RAILS; r++) begin
            if ((&rail_in[r][WIDE_W-1:W-1]) || !(|rail_in[r][WIDE_W-1:W-1])) begin
                rail_out[r] = rail_in[r][W-1:0];
                rail_pos[r] = 1'b0;
                rail_neg[r] = 1'b0;
            end else if (rail_in[r][WIDE_W-1]) begin
                rail_out[r] = {1'b1, {(W-1){1'b0}}};
                rail_pos[r] = 1'b0;
                rail_neg[r] = 1'b1;
            end else begin
                rail_out[r] = {1'b0, {(W-1){1'b1}}};
                rail_pos[r] = 1'b1;
                rail_neg[r] = 1'b0;
            end
        end
    end

    assign sample_next = '{inph: rail_out[0], quad: rail_out[1]};
    assign oflow_next  = '{inph_pos: rail_pos[0], inph_neg: rail_neg[0],
                           quad_pos: rail_pos[1], quad_neg: rail_neg[1]};

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_sample <= '0;
            o_oflow  <= '0;
            o_valid  <= 1'b0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                o_sample <= sample_next;
                o_oflow  <= oflow_next;
            end
        end
    end

endmodule : iq_saturator

`default_nettype wire

// ==== testbench/ddc_backend_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddc_backend_assert (
    input wire logic                i_clock,
    input wire logic                i_reset,
    input wire ddc_pkg::iq_sample_t i_dec_sample,
    input wire logic                i_dec_valid,
    input wire logic                i_fir_ready,
    input wire logic                i_fir_valid,
    input wire ddc_pkg::iq_oflow_t  i_oflow
);
    import ddc_pkg::*;

    logic [4:0] busy_left;

    // Cycles left in the FIR busy window
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            busy_left <= '0;
        end else if (i_dec_valid && i_fir_ready) begin
            busy_left <= 5'd16;
        end else if (busy_left != '0) begin
            busy_left <= busy_left - 1'b1;
        end
    end

    assert property (@(posedge i_clock) disable iff (i_reset)
        i_dec_valid && !i_fir_ready |=> i_dec_valid && $stable(i_dec_sample))
        else $error("dec_valid dropped or dec_sample moved before acceptance");

    assert property (@(posedge i_clock) disable iff (i_reset)
        busy_left != '0 |-> !i_fir_ready)
        else $error("fir_ready rose inside the busy window");

    assert property (@(posedge i_clock) disable iff (i_reset)
        i_fir_valid |=> !i_fir_valid)
        else $error("fir_valid longer than one cycle");

    assert property (@(posedge i_clock) disable iff (i_reset)
        !(i_oflow.inph_pos && i_oflow.inph_neg) && !(i_oflow.quad_pos && i_oflow.quad_neg))
        else $error("both overflow flags of one rail are set");

endmodule

bind ddc_backend ddc_backend_assert i_assert (
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .i_dec_sample (dec_sample),
    .i_dec_valid  (dec_valid),
    .i_fir_ready  (fir_ready),
    .i_fir_valid  (fir_valid),
    .i_oflow      (o_oflow)
);

`default_nettype wire

// ==== testbench/ddc_backend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ddc_cfg.svh"

module ddc_backend_tb;
    import ddc_pkg::*;

    localparam int    RESET_CYCLES   = 5;
    localparam int    TIMEOUT_CYCLES = 2000;
    localparam int    QUIET_CYCLES   = 200;
    localparam string TRACE_FILE     = "testbench/ddc_backend_trace.txt";

    logic       i_clock;
    logic       i_reset;
    iq_sample_t i_sample;
    logic       i_valid;
    iq_sample_t o_sample;
    iq_oflow_t  o_oflow;
    logic       o_valid;

    // Input runs from S records
    int         stim_count [$];
    iq_sample_t stim_value [$];
    int         stim_gap   [$];

    // One entry per expected output in order
    bit         exp_care   [$];
    iq_sample_t exp_sample [$];
    iq_oflow_t  exp_oflow  [$];

    int outputs_seen;

    ddc_backend i_dut (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_sample (i_sample),
        .i_valid  (i_valid),
        .o_sample (o_sample),
        .o_oflow  (o_oflow),
        .o_valid  (o_valid)
    );

    initial begin
        i_clock = 1'b0;
        forever #2 i_clock = ~i_clock;
    end

    // Output pulses counted apart from the compare loop
    always @(negedge i_clock) begin
        if (!i_reset && o_valid) begin
            outputs_seen++;
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_sample(input string name, input iq_sample_t got,
                                  input iq_sample_t expected);
        if (got !== expected) begin
            report_failure($sformatf("FAILED %s got %h expected %h", name, got, expected));
        end
    endtask

    task automatic compare_oflow(input string name, input iq_oflow_t got,
                                 input iq_oflow_t expected);
        if (got !== expected) begin
            report_failure($sformatf("FAILED %s got %h expected %h", name, got, expected));
        end
    endtask

    task automatic read_trace();
        int                    fd;
        int                    fields;
        int                    count;
        int                    gap;
        int                    care;
        logic [`DDC_WIDTH-1:0] inph;
        logic [`DDC_WIDTH-1:0] quad;
        logic [3:0]            flags;
        iq_sample_t            value;
        string                 line;
        string                 rest;
        byte                   kind;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            report_failure("could not open the trace file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2) begin
                continue;
            end
            kind = line.getc(0);
            rest = line.substr(1, line.len() - 1);
            if (kind == "S") begin
                fields = $sscanf(rest, "%d %h %h %d", count, inph, quad, gap);
                if (fields != 4) begin
                    report_failure("a stimulus record in the trace file is malformed");
                end
                value.inph = inph;
                value.quad = quad;
                stim_count.push_back(count);
                stim_value.push_back(value);
                stim_gap.push_back(gap);
            end else if (kind == "E") begin
                fields = $sscanf(rest, "%d %d %h %h %h", count, care, inph, quad, flags);
                if (fields != 5) begin
                    report_failure("an expected record in the trace file is malformed");
                end
                value.inph = inph;
                value.quad = quad;
                for (int n = 0; n < count; n++) begin
                    exp_care.push_back(care != 0);
                    exp_sample.push_back(value);
                    exp_oflow.push_back(iq_oflow_t'(flags));
                end
            end else if (kind != "#") begin
                report_failure("the trace file holds a record of unknown kind");
            end
        end
        $fclose(fd);
    endtask

    // Gap is the number of idle cycles after each strobe
    task automatic drive_stimulus();
        for (int r = 0; r < stim_count.size(); r++) begin
            for (int n = 0; n < stim_count[r]; n++) begin
                @(posedge i_clock);
                i_sample <= stim_value[r];
                i_valid  <= 1'b1;
                for (int g = 0; g < stim_gap[r]; g++) begin
                    @(posedge i_clock);
                    i_valid <= 1'b0;
                end
            end
        end
        @(posedge i_clock);
        i_valid <= 1'b0;
    endtask

    task automatic wait_for_output();
        int waited;
        waited = 0;
        @(negedge i_clock);
        while (!o_valid) begin
            if (waited >= TIMEOUT_CYCLES) begin
                report_failure("no output arrived within 2000 cycles");
            end
            waited++;
            @(negedge i_clock);
        end
    endtask

    // Results are matched by order and not by cycle
    task automatic check_outputs();
        for (int k = 0; k < exp_sample.size(); k++) begin
            wait_for_output();
            if (exp_care[k]) begin
                compare_sample($sformatf("o_sample[%0d]", k), o_sample, exp_sample[k]);
                compare_oflow($sformatf("o_oflow[%0d]", k), o_oflow, exp_oflow[k]);
            end
        end
    endtask

    task automatic expect_quiet_output();
        for (int c = 0; c < QUIET_CYCLES; c++) begin
            @(negedge i_clock);
            if (o_valid) begin
                report_failure("the DUT produced more outputs than the trace expects");
            end
        end
    endtask

    initial begin
        i_reset      = 1'b1;
        i_valid      = 1'b0;
        i_sample     = '0;
        outputs_seen = 0;
        read_trace();
        repeat (RESET_CYCLES) @(posedge i_clock);
        i_reset <= 1'b0;
        fork
            drive_stimulus();
            check_outputs();
        join
        expect_quiet_output();
        if (outputs_seen != exp_sample.size()) begin
            report_failure("the number of DUT outputs does not match the expected records");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/ddc_backend_trace.txt ====
# S count inph quad gap -- count strobes of one I/Q value in hex, gap idle cycles after each
# E count care inph quad flags -- count outputs in order, care 0 skips the compare
# flags hex, bits 3 to 0 are inph_pos inph_neg quad_pos quad_neg
# Counts of S records are whole decimation blocks of 32 strobes
# Zero input from reset
S 256 0000 0000 0
E 8 1 0000 0000 0
# DC step with opposite rails, FIR DC gain is -0.5
S 1280 03e8 fc18 0
E 34 0 0000 0000 0
E 6 1 fe0c 01f4 0
# Half remainders, I rounds up to even and Q rounds down to even
S 1280 03e9 03eb 0
E 34 0 0000 0000 0
E 6 1 fe0c fe0a 0
# Full scale, I negative and Q positive
S 1280 8000 7fff 0
E 34 0 0000 0000 0
E 6 1 4000 c000 0
# Swing to the opposite full scale, overshoot clamps at outputs 15 and 20
S 1280 7fff 8000 0
E 14 0 0000 0000 0
E 1 1 7fff 8000 9
E 4 0 0000 0000 0
E 1 1 8000 7fff 6
E 14 0 0000 0000 0
E 6 1 c000 4000 0
# Same two full scale steps with gapped strobes
S 1280 8000 7fff 2
E 34 0 0000 0000 0
E 6 1 4000 c000 0
S 1280 7fff 8000 3
E 14 0 0000 0000 0
E 1 1 7fff 8000 9
E 4 0 0000 0000 0
E 1 1 8000 7fff 6
E 14 0 0000 0000 0
E 6 1 c000 4000 0

// ==== verilog.f ====
+incdir+source
source/ddc_pkg.sv
source/cic_decimator.sv
source/cic_compfir.sv
source/iq_saturator.sv
source/ddc_backend.sv
testbench/ddc_backend_assert.sv
testbench/ddc_backend_tb.sv
